// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := intPipeTb
FILELIST   := intPipe.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Verification failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== intPipe.f ====
source/pipePkg.sv
source/regFile.sv
source/instrDecode.sv
source/aluExecute.sv
source/memResult.sv
source/intPipe.sv
sim/intPipe_sva.sv
sim/intPipeTb.sv

// ==== sim/intPipeTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module intPipeTb;

    typedef struct packed {
        logic [31:0]        due;     // cycle count when the report shows
        logic               isExc;
        pipePkg::wbInfo_t   wb;
        pipePkg::excInfo_t  exc;
    } expReport_t;

    typedef struct packed {
        logic [31:0]          due;
        pipePkg::dataMemReq_t req;
    } expStore_t;

    logic                 clk;
    logic                 rstN;
    logic                 instrValid;
    logic [31:0]          instr;
    pipePkg::dataMemReq_t memReq;
    logic [31:0]          readData;
    logic                 wbValid;
    pipePkg::wbInfo_t     wb;
    logic                 excValid;
    pipePkg::excInfo_t    exc;

    logic [31:0] mem [64];
    logic [31:0] shadowMem [64];
    logic [31:0] shadowRegs [32];
    expReport_t  reportQ [$];
    expStore_t   storeQ [$];
    logic [31:0] cycle = 32'd0;
    int          mismatches = 0;
    int          otherErrors = 0;

    intPipe u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .memReq     (memReq),
        .readData   (readData),
        .wbValid    (wbValid),
        .wb         (wb),
        .excValid   (excValid),
        .exc        (exc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] fillWord(input logic [5:0] idx);
        return ({26'b0, idx} * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] en);
        logic [31:0] mask;
        mask = {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    // data memory, read is combinational from the word address
    assign readData = mem[memReq.addr[7:2]];

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 64; i++)
                mem[i[5:0]] <= fillWord(i[5:0]);
        end else if (memReq.byteEn != 4'b0000) begin
            mem[memReq.addr[7:2]] <= mergeBytes(mem[memReq.addr[7:2]], memReq.wdata,
                                                memReq.byteEn);
        end
    end

    function automatic logic [31:0] pickBelow(input logic [31:0] n);
        return $urandom % n;
    endfunction

    function automatic logic [31:0] makeInstr();
        logic [31:0] kind;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] rd;
        logic [31:0] op;
        logic [31:0] fn;
        logic [31:0] off;
        logic [31:0] ins;
        kind = pickBelow(100);
        rs = pickBelow(8);    // few registers, lots of dependencies
        rt = pickBelow(8);
        rd = pickBelow(8);
        if (kind < 35) begin
            case (pickBelow(13))
                0: fn = 32'h20;
                1: fn = 32'h21;
                2: fn = 32'h22;
                3: fn = 32'h23;
                4: fn = 32'h24;
                5: fn = 32'h25;
                6: fn = 32'h26;
                7: fn = 32'h27;
                8: fn = 32'h2a;
                9: fn = 32'h2b;
                10: fn = 32'h00;
                11: fn = 32'h02;
                default: fn = 32'h03;
            endcase
            ins = (rs << 21) | (rt << 16) | (rd << 11) | (pickBelow(32) << 6) | fn;
        end else if (kind < 65) begin
            ins = ((32'h08 + pickBelow(8)) << 26) | (rs << 21) | (rt << 16) |
                  pickBelow(32'h1_0000);
        end else if (kind < 95) begin
            case (pickBelow(8))
                0: op = 32'h23;    // LW
                1: op = 32'h21;    // LH
                2: op = 32'h25;    // LHU
                3: op = 32'h20;    // LB
                4: op = 32'h24;    // LBU
                5: op = 32'h2b;    // SW
                6: op = 32'h29;    // SH
                default: op = 32'h28;
            endcase
            // half of the accesses crowd into 8 words so loads hit recent stores
            off = (pickBelow(2) == 0) ? pickBelow(8) * 4 : pickBelow(64) * 4;
            if (op[1:0] == 2'b01)
                off = off + 2 * pickBelow(2);
            else if (op[1:0] == 2'b00)
                off = off + pickBelow(4);
            if (op[1:0] != 2'b00 && pickBelow(10) == 0)
                off = off + 1;    // misaligned on purpose
            // low address byte comes out as off whatever the base register holds
            ins = (op << 26) | (rs << 21) | (rt << 16) | ((off - shadowRegs[rs[4:0]]) & 32'hff);
        end else begin
            case (pickBelow(6))
                0: ins = (32'h02 << 26) | ($urandom & 32'h03ff_ffff);    // J
                1: ins = (32'h04 << 26) | ($urandom & 32'h03ff_ffff);    // BEQ
                2: ins = (32'h10 << 26) | ($urandom & 32'h03ff_ffff);    // COP0
                3: ins = (32'h22 << 26) | ($urandom & 32'h03ff_ffff);    // LWL
                4: ins = (rs << 21) | (rt << 16) | 32'h0c;               // SYSCALL
                default: ins = (rs << 21) | (rt << 16) | 32'h1a;         // DIV
            endcase
        end
        return ins;
    endfunction

    // executes one instruction in program order and queues what the ports must show
    function automatic void refExec(input logic [31:0] ins, input logic [31:0] issue);
        logic [5:0]        op;
        logic [4:0]        sh;
        logic [4:0]        dest;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       immS;
        logic [31:0]       res;
        logic [31:0]       addr;
        logic [31:0]       word;
        logic [15:0]       half;
        logic [7:0]        byt;
        logic              writes;
        pipePkg::excCode_e code;
        expReport_t        rep;
        expStore_t         st;
        op = ins[31:26];
        sh = ins[10:6];
        a = shadowRegs[ins[25:21]];
        b = shadowRegs[ins[20:16]];
        immS = {{16{ins[15]}}, ins[15:0]};
        dest = ins[20:16];
        res = '0;
        addr = a + immS;
        writes = 1'b1;
        code = pipePkg::ExcNone;
        case (op)
            6'h00: begin
                dest = ins[15:11];
                case (ins[5:0])
                    6'h20, 6'h21: res = a + b;
                    6'h22, 6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b: res = (a < b) ? 32'd1 : 32'd0;
                    6'h00: res = b << sh;
                    6'h02: res = b >> sh;
                    6'h03: res = $signed(b) >>> sh;
                    default: code = pipePkg::ExcRi;
                endcase
                if (ins[5:0] == 6'h20 && a[31] == b[31] && res[31] != a[31])
                    code = pipePkg::ExcOv;
                if (ins[5:0] == 6'h22 && a[31] != b[31] && res[31] != a[31])
                    code = pipePkg::ExcOv;
            end
            6'h08: begin
                res = a + immS;
                if (a[31] == immS[31] && res[31] != a[31])
                    code = pipePkg::ExcOv;
            end
            6'h09: res = a + immS;
            6'h0a: res = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
            6'h0b: res = (a < immS) ? 32'd1 : 32'd0;
            6'h0c: res = a & {16'b0, ins[15:0]};
            6'h0d: res = a | {16'b0, ins[15:0]};
            6'h0e: res = a ^ {16'b0, ins[15:0]};
            6'h0f: res = {ins[15:0], 16'b0};
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
                if ((op[1:0] == 2'b11 && addr[1:0] != 2'b00) || (op[1:0] == 2'b01 && addr[0]))
                    code = pipePkg::ExcAdEL;
                word = shadowMem[addr[7:2]];
                half = addr[1] ? word[31:16] : word[15:0];
                case (addr[1:0])
                    2'b00: byt = word[7:0];
                    2'b01: byt = word[15:8];
                    2'b10: byt = word[23:16];
                    default: byt = word[31:24];
                endcase
                if (op[1:0] == 2'b11)
                    res = word;
                else if (op[1:0] == 2'b01)
                    res = op[2] ? {16'b0, half} : {{16{half[15]}}, half};
                else
                    res = op[2] ? {24'b0, byt} : {{24{byt[7]}}, byt};
            end
            6'h28, 6'h29, 6'h2b: begin
                writes = 1'b0;
                if ((op[1:0] == 2'b11 && addr[1:0] != 2'b00) || (op[1:0] == 2'b01 && addr[0]))
                    code = pipePkg::ExcAdES;
                st.due = issue + 3;    // memReq is live one cycle before the reports
                st.req.addr = addr;
                if (op[1:0] == 2'b11) begin
                    st.req.wdata = b;
                    st.req.byteEn = 4'b1111;
                end else if (op[1:0] == 2'b01) begin
                    st.req.wdata = {b[15:0], b[15:0]};
                    st.req.byteEn = addr[1] ? 4'b1100 : 4'b0011;
                end else begin
                    st.req.wdata = {b[7:0], b[7:0], b[7:0], b[7:0]};
                    case (addr[1:0])
                        2'b00: st.req.byteEn = 4'b0001;
                        2'b01: st.req.byteEn = 4'b0010;
                        2'b10: st.req.byteEn = 4'b0100;
                        default: st.req.byteEn = 4'b1000;
                    endcase
                end
                if (code == pipePkg::ExcNone) begin
                    shadowMem[addr[7:2]] = mergeBytes(shadowMem[addr[7:2]], st.req.wdata,
                                                      st.req.byteEn);
                    storeQ.push_back(st);
                end
            end
            default: code = pipePkg::ExcRi;
        endcase
        rep = '0;
        rep.due = issue + 4;
        if (code != pipePkg::ExcNone) begin
            rep.isExc = 1'b1;
            rep.exc.code = code;
            if (code == pipePkg::ExcAdEL || code == pipePkg::ExcAdES)
                rep.exc.badVAddr = addr;
            reportQ.push_back(rep);
        end else if (writes && dest != 5'd0) begin
            shadowRegs[dest] = res;
            rep.wb.regNum = dest;
            rep.wb.data = res;
            reportQ.push_back(rep);
        end
    endfunction

    task automatic checkWb(input pipePkg::wbInfo_t expWb);
        if (wb !== expWb) begin
            mismatches++;
            $display("Mismatch at %0t: wb expected reg %0d data %h, got reg %0d data %h",
                     $time, expWb.regNum, expWb.data, wb.regNum, wb.data);
        end
    endtask

    task automatic checkStore(input pipePkg::dataMemReq_t expReq);
        if (memReq !== expReq) begin
            mismatches++;
            $display("Mismatch at %0t: memReq expected %h/%h/%b, got %h/%h/%b", $time,
                     expReq.addr, expReq.wdata, expReq.byteEn,
                     memReq.addr, memReq.wdata, memReq.byteEn);
        end
    endtask

    task automatic checkExc(input pipePkg::excInfo_t expExc);
        if (exc !== expExc) begin
            mismatches++;
            $display("Mismatch at %0t: exc expected code %h addr %h, got code %h addr %h",
                     $time, expExc.code, expExc.badVAddr, exc.code, exc.badVAddr);
        end
    endtask

    task automatic checkCycle();
        expReport_t rep;
        expStore_t  st;
        if (memReq.byteEn != 4'b0000) begin
            if (storeQ.size() > 0 && storeQ[0].due == cycle) begin
                st = storeQ.pop_front();
                checkStore(st.req);
            end else begin
                otherErrors++;
                $display("%0t: store to %h appeared with no store pending", $time, memReq.addr);
            end
        end else if (storeQ.size() > 0 && storeQ[0].due == cycle) begin
            st = storeQ.pop_front();
            otherErrors++;
            $display("%0t: expected store to %h never appeared", $time, st.req.addr);
        end
        if (wbValid || excValid) begin
            if (reportQ.size() > 0 && reportQ[0].due == cycle) begin
                rep = reportQ.pop_front();
                if (rep.isExc && excValid) begin
                    checkExc(rep.exc);
                end else if (!rep.isExc && wbValid) begin
                    checkWb(rep.wb);
                end else begin
                    otherErrors++;
                    $display("%0t: got the wrong kind of report, exception expected %0b",
                             $time, rep.isExc);
                end
            end else begin
                otherErrors++;
                $display("%0t: write-back or exception reported with nothing pending", $time);
            end
        end else if (reportQ.size() > 0 && reportQ[0].due == cycle) begin
            rep = reportQ.pop_front();
            otherErrors++;
            $display("%0t: expected report missing, exception expected %0b", $time, rep.isExc);
        end
    endtask

    // comparing process, samples mid-cycle
    initial begin
        int waited;
        waited = 0;
        while (rstN !== 1'b1 && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (rstN !== 1'b1) begin
            otherErrors++;
            $display("%0t: reset was never released", $time);
        end
        forever begin
            @(negedge clk);
            checkCycle();
        end
    end

    initial begin
        logic [31:0] ins;
        int          waited;
        void'($urandom(64102));
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        for (int i = 0; i < 32; i++)
            shadowRegs[i[4:0]] = '0;
        for (int i = 0; i < 64; i++)
            shadowMem[i[5:0]] = fillWord(i[5:0]);
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        for (int n = 0; n < 4000; n++) begin
            if (pickBelow(100) < 8) begin
                instrValid = 1'b0;
                instr = $urandom;    // junk that must not execute
            end else begin
                ins = makeInstr();
                instrValid = 1'b1;
                instr = ins;
                refExec(ins, cycle);
            end
            @(negedge clk);
        end
        instrValid = 1'b0;
        waited = 0;
        while ((reportQ.size() > 0 || storeQ.size() > 0) && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (reportQ.size() > 0 || storeQ.size() > 0) begin
            otherErrors++;
            $display("%0t: drain timed out with %0d reports and %0d stores outstanding",
                     $time, reportQ.size(), storeQ.size());
        end
        repeat (3) @(negedge clk);    // quiet window to catch stray events
        $display("errors: %0d mismatches, %0d other", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/intPipe_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module intPipe_sva (
    input logic                 clk,
    input logic                 rstN,
    input logic                 wbValid,
    input logic                 excValid,
    input pipePkg::dataMemReq_t memReq
);

    // pipeline comes out of reset with nothing in flight
    resetQuiet: assert property (@(posedge clk)
        !rstN |=> (!wbValid && !excValid && memReq.byteEn == 4'b0000))
        else $error("report or store active right after reset");

    oneReport: assert property (@(posedge clk) disable iff (!rstN)
        !(wbValid && excValid))
        else $error("wbValid and excValid high in the same cycle");

    // word, half lanes, single byte lanes or idle
    legalByteEn: assert property (@(posedge clk) disable iff (!rstN)
        memReq.byteEn inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                              4'b0011, 4'b1100, 4'b1111})
        else $error("illegal byteEn pattern %b", memReq.byteEn);

endmodule

bind intPipe intPipe_sva u_sva (
    .clk      (clk),
    .rstN     (rstN),
    .wbValid  (wbValid),
    .excValid (excValid),
    .memReq   (memReq)
);

`default_nettype wire

// ==== source/aluExecute.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluExecute (
    input  logic               clk,
    input  logic               rstN,
    input  pipePkg::execReq_t  execReq,
    input  pipePkg::regWrite_t regWr,
    output pipePkg::memReq_t   memStage
);

    logic [pipePkg::DataW-1:0] rsFwd;
    logic [pipePkg::DataW-1:0] rtFwd;
    logic [pipePkg::DataW-1:0] srcB;
    logic [pipePkg::DataW-1:0] sum;
    logic [pipePkg::DataW-1:0] diff;
    logic [pipePkg::DataW-1:0] aluRes;
    logic                      addOv;
    logic                      subOv;
    pipePkg::memReq_t          memNext;

    // result stage value overrides the stale register read
    assign rsFwd = (regWr.en && regWr.num != '0 && regWr.num == execReq.rsNum) ?
                   regWr.data : execReq.rsVal;
    assign rtFwd = (regWr.en && regWr.num != '0 && regWr.num == execReq.rtNum) ?
                   regWr.data : execReq.rtVal;

    assign srcB = execReq.ctrl.useImm ? execReq.imm : rtFwd;
    assign sum  = rsFwd + srcB;
    assign diff = rsFwd - srcB;

    // signed overflow, sign of result differs from matching operand signs
    assign addOv = (rsFwd[31] == srcB[31]) && (sum[31] != rsFwd[31]);
    assign subOv = (rsFwd[31] != srcB[31]) && (diff[31] != rsFwd[31]);

    always_comb begin
        case (execReq.ctrl.aluOp)
            pipePkg::AluSub:  aluRes = diff;
            pipePkg::AluAnd:  aluRes = rsFwd & srcB;
            pipePkg::AluOr:   aluRes = rsFwd | srcB;
            pipePkg::AluXor:  aluRes = rsFwd ^ srcB;
            pipePkg::AluNor:  aluRes = ~(rsFwd | srcB);
            pipePkg::AluSlt:  aluRes = {31'b0, $signed(rsFwd) < $signed(srcB)};
            pipePkg::AluSltu: aluRes = {31'b0, rsFwd < srcB};
            pipePkg::AluSll:  aluRes = srcB << execReq.shamt;
            pipePkg::AluSrl:  aluRes = srcB >> execReq.shamt;
            pipePkg::AluSra:  aluRes = $signed(srcB) >>> execReq.shamt;
            pipePkg::AluLui:  aluRes = {srcB[15:0], 16'b0};
            default:          aluRes = sum;    // also load/store address
        endcase
    end

    always_comb begin
        memNext.valid    = execReq.valid;
        memNext.ctrl     = execReq.ctrl;
        memNext.aluVal   = aluRes;
        memNext.storeVal = rtFwd;
        memNext.destNum  = execReq.destNum;
        memNext.ovFlag   = execReq.ctrl.checkOv &&
                           (execReq.ctrl.aluOp == pipePkg::AluSub ? subOv : addOv);
    end

    always_ff @(posedge clk) begin
        memStage <= memNext;
        if (!rstN)
            memStage.valid <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== source/instrDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      instrValid,
    input  logic [pipePkg::DataW-1:0] instr,
    input  pipePkg::regWrite_t        regWr,
    output pipePkg::execReq_t         execReq
);

    logic                         instrValidR;
    logic [pipePkg::DataW-1:0]    instrR;
    logic [5:0]                   opcode;
    logic [5:0]                   funct;
    logic [pipePkg::RegAddrW-1:0] rs;
    logic [pipePkg::RegAddrW-1:0] rt;
    logic [pipePkg::RegAddrW-1:0] rd;
    logic [15:0]                  imm16;
    logic [pipePkg::DataW-1:0]    rsVal;
    logic [pipePkg::DataW-1:0]    rtVal;
    pipePkg::aluOp_e              rAluOp;
    logic                         rOk;
    logic                         rLegal;
    logic                         memLegal;
    logic                         useRd;
    logic                         zeroExt;
    pipePkg::ctrl_t               ctrl;
    pipePkg::execReq_t            execNext;

    always_ff @(posedge clk) begin
        if (!rstN)
            instrValidR <= 1'b0;
        else
            instrValidR <= instrValid;
    end

    always_ff @(posedge clk) begin
        instrR <= instr;
    end

    assign opcode = instrR[31:26];
    assign rs     = instrR[25:21];
    assign rt     = instrR[20:16];
    assign rd     = instrR[15:11];
    assign funct  = instrR[5:0];
    assign imm16  = instrR[15:0];

    // SPECIAL function field
    always_comb begin
        rAluOp = pipePkg::AluAdd;
        rOk = 1'b1;
        case (funct)
            6'h20, 6'h21: rAluOp = pipePkg::AluAdd;
            6'h22, 6'h23: rAluOp = pipePkg::AluSub;
            6'h24: rAluOp = pipePkg::AluAnd;
            6'h25: rAluOp = pipePkg::AluOr;
            6'h26: rAluOp = pipePkg::AluXor;
            6'h27: rAluOp = pipePkg::AluNor;
            6'h2a: rAluOp = pipePkg::AluSlt;
            6'h2b: rAluOp = pipePkg::AluSltu;
            6'h00: rAluOp = pipePkg::AluSll;
            6'h02: rAluOp = pipePkg::AluSrl;
            6'h03: rAluOp = pipePkg::AluSra;
            default: rOk = 1'b0;    // SYSCALL, BREAK, JR, HI/LO ... all reserved
        endcase
    end

    assign rLegal = rOk && opcode[2:0] == 3'b000;
    // LB LH LW LBU LHU, SB SH SW
    assign memLegal = opcode[1:0] != 2'b10 && !(opcode[2] && (opcode[3] || opcode[1]));

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = pipePkg::AluAdd;
        ctrl.memSize = pipePkg::MemNone;
        useRd = 1'b0;
        zeroExt = 1'b0;
        case (opcode[5:3])
            3'b000: begin
                useRd = 1'b1;
                ctrl.aluOp = rAluOp;
                ctrl.regWrite = rLegal;
                ctrl.checkOv = rLegal && funct[5:2] == 4'b1000 && !funct[0];
                ctrl.illegal = !rLegal;
            end
            3'b001: begin
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.checkOv = opcode[2:0] == 3'b000;           // ADDI only
                zeroExt = opcode[2] && opcode[1:0] != 2'b11;    // ANDI ORI XORI
                case (opcode[2:0])
                    3'b010: ctrl.aluOp = pipePkg::AluSlt;
                    3'b011: ctrl.aluOp = pipePkg::AluSltu;
                    3'b100: ctrl.aluOp = pipePkg::AluAnd;
                    3'b101: ctrl.aluOp = pipePkg::AluOr;
                    3'b110: ctrl.aluOp = pipePkg::AluXor;
                    3'b111: ctrl.aluOp = pipePkg::AluLui;
                    default: ctrl.aluOp = pipePkg::AluAdd;
                endcase
            end
            3'b100, 3'b101: begin
                ctrl.useImm = 1'b1;
                ctrl.illegal = !memLegal;
                ctrl.memRead = memLegal && !opcode[3];
                ctrl.memWrite = memLegal && opcode[3];
                ctrl.regWrite = memLegal && !opcode[3];
                ctrl.loadUnsigned = opcode[2];
                if (!memLegal)
                    ctrl.memSize = pipePkg::MemNone;
                else if (opcode[1])
                    ctrl.memSize = pipePkg::MemWord;
                else if (opcode[0])
                    ctrl.memSize = pipePkg::MemHalf;
                else
                    ctrl.memSize = pipePkg::MemByte;
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

    regFile u_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rdNumA (rs),
        .rdNumB (rt),
        .rdValA (rsVal),
        .rdValB (rtVal),
        .wr     (regWr)
    );

    always_comb begin
        execNext.valid   = instrValidR;
        execNext.ctrl    = ctrl;
        execNext.rsNum   = rs;
        execNext.rtNum   = rt;
        execNext.rsVal   = rsVal;
        execNext.rtVal   = rtVal;
        execNext.imm     = zeroExt ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
        execNext.shamt   = instrR[10:6];
        execNext.destNum = useRd ? rd : rt;
    end

    always_ff @(posedge clk) begin
        execReq <= execNext;
        if (!rstN)
            execReq.valid <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== source/intPipe.sv ====
`timescale 1ns/10ps
`default_nettype none

module intPipe (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      instrValid,
    input  logic [pipePkg::DataW-1:0] instr,
    output pipePkg::dataMemReq_t      memReq,
    input  logic [pipePkg::DataW-1:0] readData,
    output logic                      wbValid,
    output pipePkg::wbInfo_t          wb,
    output logic                      excValid,
    output pipePkg::excInfo_t         exc
);

    pipePkg::execReq_t  execReq;
    pipePkg::memReq_t   memStage;
    pipePkg::regWrite_t regWr;    // to the register file and the forwarding muxes

    instrDecode u_instrDecode (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .regWr      (regWr),
        .execReq    (execReq)
    );

    aluExecute u_aluExecute (
        .clk      (clk),
        .rstN     (rstN),
        .execReq  (execReq),
        .regWr    (regWr),
        .memStage (memStage)
    );

    memResult u_memResult (
        .clk      (clk),
        .rstN     (rstN),
        .memStage (memStage),
        .readData (readData),
        .memReq   (memReq),
        .regWr    (regWr),
        .wbValid  (wbValid),
        .wb       (wb),
        .excValid (excValid),
        .exc      (exc)
    );

endmodule

`default_nettype wire

// ==== source/memResult.sv ====
`timescale 1ns/10ps
`default_nettype none

module memResult (
    input  logic                      clk,
    input  logic                      rstN,
    input  pipePkg::memReq_t          memStage,
    input  logic [pipePkg::DataW-1:0] readData,
    output pipePkg::dataMemReq_t      memReq,
    output pipePkg::regWrite_t        regWr,
    output logic                      wbValid,
    output pipePkg::wbInfo_t          wb,
    output logic                      excValid,
    output pipePkg::excInfo_t         exc
);

    logic [pipePkg::DataW-1:0] addr;
    logic                      misaligned;
    logic                      adEL;
    logic                      adES;
    pipePkg::excCode_e         excCode;
    logic                      excHit;
    logic [15:0]               halfLane;
    logic [7:0]                byteLane;
    logic [pipePkg::DataW-1:0] loadVal;

    assign addr = memStage.aluVal;

    always_comb begin
        case (memStage.ctrl.memSize)
            pipePkg::MemWord: misaligned = |addr[1:0];
            pipePkg::MemHalf: misaligned = addr[0];
            default:          misaligned = 1'b0;
        endcase
    end

    assign adEL = memStage.valid && memStage.ctrl.memRead && misaligned;
    assign adES = memStage.valid && memStage.ctrl.memWrite && misaligned;

    // load address, store address, reserved, overflow
    always_comb begin
        excCode = pipePkg::ExcNone;
        if (adEL)
            excCode = pipePkg::ExcAdEL;
        else if (adES)
            excCode = pipePkg::ExcAdES;
        else if (memStage.valid && memStage.ctrl.illegal)
            excCode = pipePkg::ExcRi;
        else if (memStage.valid && memStage.ovFlag)
            excCode = pipePkg::ExcOv;
    end

    assign excHit = excCode != pipePkg::ExcNone;

    always_comb begin
        memReq.addr = addr;
        memReq.wdata = memStage.storeVal;
        memReq.byteEn = 4'b1111;
        case (memStage.ctrl.memSize)
            pipePkg::MemHalf: begin
                memReq.wdata = {2{memStage.storeVal[15:0]}};
                memReq.byteEn = addr[1] ? 4'b1100 : 4'b0011;
            end
            pipePkg::MemByte: begin
                memReq.wdata = {4{memStage.storeVal[7:0]}};
                memReq.byteEn = 4'b0001 << addr[1:0];
            end
            default: ;
        endcase
        if (!(memStage.valid && memStage.ctrl.memWrite) || excHit)
            memReq.byteEn = '0;    // an excepting store leaves memory alone
    end

    assign halfLane = addr[1] ? readData[31:16] : readData[15:0];
    assign byteLane = readData[{addr[1:0], 3'b000} +: 8];

    always_comb begin
        case (memStage.ctrl.memSize)
            pipePkg::MemHalf:
                loadVal = {{16{halfLane[15] && !memStage.ctrl.loadUnsigned}}, halfLane};
            pipePkg::MemByte:
                loadVal = {{24{byteLane[7] && !memStage.ctrl.loadUnsigned}}, byteLane};
            default:
                loadVal = readData;
        endcase
    end

    always_comb begin
        regWr.en   = memStage.valid && !excHit && memStage.ctrl.regWrite &&
                     memStage.destNum != '0;
        regWr.num  = memStage.destNum;
        regWr.data = memStage.ctrl.memRead ? loadVal : memStage.aluVal;
    end

    always_ff @(posedge clk) begin
        wb.regNum    <= regWr.num;
        wb.data      <= regWr.data;
        exc.code     <= excCode;
        exc.badVAddr <= (adEL || adES) ? addr : '0;
        if (!rstN) begin
            wbValid  <= 1'b0;
            excValid <= 1'b0;
        end else begin
            wbValid  <= regWr.en;
            excValid <= excHit;
        end
    end

endmodule

`default_nettype wire

// ==== source/pipePkg.sv ====
`default_nettype none

package pipePkg;

    localparam int DataW    = 32;
    localparam int RegAddrW = 5;
    localparam int NumRegs  = 32;

    // ADDU and SUBU share AluAdd / AluSub, only checkOv differs
    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluNor,
        AluSlt,
        AluSltu,
        AluSll,
        AluSrl,
        AluSra,
        AluLui
    } aluOp_e;

    typedef enum logic [1:0] {
        MemNone,
        MemByte,
        MemHalf,
        MemWord
    } memSize_e;

    // MIPS cause register codes
    typedef enum logic [4:0] {
        ExcNone = 5'h00,
        ExcAdEL = 5'h04,
        ExcAdES = 5'h05,
        ExcRi   = 5'h0a,
        ExcOv   = 5'h0c
    } excCode_e;

    typedef struct packed {
        aluOp_e   aluOp;
        logic     useImm;       // second operand is imm, not rt
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        memSize_e memSize;
        logic     loadUnsigned;
        logic     checkOv;      // ADD, SUB, ADDI trap on overflow
        logic     illegal;
    } ctrl_t;

    typedef struct packed {
        logic                valid;
        ctrl_t               ctrl;
        logic [RegAddrW-1:0] rsNum;
        logic [RegAddrW-1:0] rtNum;
        logic [DataW-1:0]    rsVal;
        logic [DataW-1:0]    rtVal;
        logic [DataW-1:0]    imm;
        logic [4:0]          shamt;
        logic [RegAddrW-1:0] destNum;
    } execReq_t;

    typedef struct packed {
        logic                valid;
        ctrl_t               ctrl;
        logic [DataW-1:0]    aluVal;    // result or effective address
        logic [DataW-1:0]    storeVal;
        logic [RegAddrW-1:0] destNum;
        logic                ovFlag;
    } memReq_t;

    typedef struct packed {
        logic                en;
        logic [RegAddrW-1:0] num;
        logic [DataW-1:0]    data;
    } regWrite_t;

    typedef struct packed {
        logic [DataW-1:0] addr;
        logic [DataW-1:0] wdata;
        logic [3:0]       byteEn;
    } dataMemReq_t;

    typedef struct packed {
        logic [RegAddrW-1:0] regNum;
        logic [DataW-1:0]    data;
    } wbInfo_t;

    typedef struct packed {
        excCode_e         code;
        logic [DataW-1:0] badVAddr;
    } excInfo_t;

endpackage

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [pipePkg::RegAddrW-1:0] rdNumA,
    input  logic [pipePkg::RegAddrW-1:0] rdNumB,
    output logic [pipePkg::DataW-1:0]    rdValA,
    output logic [pipePkg::DataW-1:0]    rdValB,
    input  pipePkg::regWrite_t           wr
);

    logic [pipePkg::DataW-1:0] regs [pipePkg::NumRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < pipePkg::NumRegs; i++)
                regs[i] <= '0;
        end else if (wr.en && wr.num != '0) begin
            regs[wr.num] <= wr.data;
        end
    end

    // $0 reads zero, a same-cycle write is passed straight through
    assign rdValA = (rdNumA == '0) ? '0 :
                    (wr.en && wr.num == rdNumA) ? wr.data : regs[rdNumA];
    assign rdValB = (rdNumB == '0) ? '0 :
                    (wr.en && wr.num == rdNumB) ? wr.data : regs[rdNumB];

endmodule

`default_nettype wire
